/* src/sdCardPkg.sv */
package sdCardPkg;

    // ============================================================
    // Frame geometry and CRC polynomials
    // ============================================================
    localparam int CMD_FRAME_BITS = 48;

    localparam int         CRC7_WIDTH = 7;
    localparam logic [6:0] CRC7_POLY  = 7'h09;

    localparam int          CRC16_WIDTH = 16;
    localparam logic [15:0] CRC16_POLY  = 16'h1021;

    localparam int DAT_LANES = 4;

    // ============================================================
    // Command indices
    // ============================================================
    localparam logic [5:0] CMD_GO_IDLE      = 6'd0;
    localparam logic [5:0] CMD_SEND_RCA     = 6'd3;
    localparam logic [5:0] CMD_SELECT       = 6'd7;
    localparam logic [5:0] CMD_SEND_IF_COND = 6'd8;
    localparam logic [5:0] CMD_STOP         = 6'd12;
    localparam logic [5:0] CMD_READ_MULTI   = 6'd18;
    localparam logic [5:0] CMD_APP          = 6'd55;
    // Only valid right after CMD55
    localparam logic [5:0] ACMD_OP_COND     = 6'd41;

    // ============================================================
    // Response contents
    // ============================================================
    localparam logic [15:0] RCA_VALUE        = 16'hAAAA;
    localparam logic [15:0] R6_STATUS        = 16'h0520;
    localparam logic [31:0] R1_STATUS_SELECT = 32'h00000700;
    localparam logic [31:0] R1_STATUS_TRAN   = 32'h00000900;
    localparam logic [31:0] R1_STATUS_APP    = 32'h00000120;

    // R3 carries the OCR with busy bit set, and no real CRC
    localparam logic [31:0] R3_OCR_READY = 32'hC1FF8080;
    localparam logic [5:0]  R3_INDEX     = 6'h3F;
    localparam logic [6:0]  R3_CRC       = 7'h7F;

    // ============================================================
    // Bus timing in card clock cycles
    // ============================================================
    localparam int NCR_CYCLES       = 2;
    localparam int BLOCK_NIBBLES    = 1024;
    localparam int BLOCK_GAP_CYCLES = 2;

endpackage

/* src/sdCrc.sv */
`timescale 1ns/1ps

module sdCrc #(
    parameter int              WIDTH = 7,
    parameter logic [WIDTH-1:0] POLY = 7'h09
) (
    input  logic             clk,
    input  logic             rst_,
    input  logic             clear,
    input  logic             enable,
    input  logic             din,
    output logic [WIDTH-1:0] crc
);

    logic             feedback;
    logic [WIDTH-1:0] crcNext;

    // Incoming bit folds into the top of the register
    assign feedback = din ^ crc[WIDTH-1];
    assign crcNext  = {crc[WIDTH-2:0], 1'b0} ^ (feedback ? POLY : '0);

    always_ff @(posedge clk) begin
        if (!rst_ || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= crcNext;
        end
    end

endmodule

/* src/sdCmdReceiver.sv */
`timescale 1ns/1ps

module sdCmdReceiver
    import sdCardPkg::*;
(
    input  logic        clk,
    input  logic        rst_,
    input  logic        cmdIn,
    output logic        cmdValid,
    output logic [5:0]  cmdIndex,
    output logic [31:0] cmdArg,
    output logic        cmdOk
);

    logic        busy;
    logic [5:0]  bitCount;
    logic [46:0] shiftReg;
    logic [6:0]  crc;
    logic        crcEnable;
    logic        frameDone;

    // Last bit of the frame is on cmdIn while bitCount sits at 47
    assign frameDone = busy && (bitCount == 6'(CMD_FRAME_BITS - 1));

    // Start bit is covered too, so enable on it while still idle
    assign crcEnable = busy ? (bitCount < 6'(CMD_FRAME_BITS - 8)) : !cmdIn;

    sdCrc #(
        .WIDTH (CRC7_WIDTH),
        .POLY  (CRC7_POLY)
    ) i_crc7 (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (frameDone),
        .enable (crcEnable),
        .din    (cmdIn),
        .crc    (crc)
    );

    // ============================================================
    // Framing
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            busy     <= 1'b0;
            bitCount <= '0;
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= frameDone;
            if (frameDone) begin
                busy <= 1'b0;
            end else if (busy) begin
                bitCount <= bitCount + 6'd1;
            end else if (!cmdIn) begin
                busy     <= 1'b1;
                bitCount <= 6'd1;
            end
        end
    end

    // Line history; at frame end it holds bits 47 down to 1
    always_ff @(posedge clk) begin
        shiftReg <= {shiftReg[45:0], cmdIn};
        if (frameDone) begin
            cmdIndex <= shiftReg[44:39];
            cmdArg   <= shiftReg[38:7];
            // Transmission bit, CRC7 and end bit
            cmdOk    <= shiftReg[45] && (shiftReg[6:0] == crc) && cmdIn;
        end
    end

endmodule

/* src/sdCmdResponder.sv */
`timescale 1ns/1ps

module sdCmdResponder
    import sdCardPkg::*;
(
    input  logic        clk,
    input  logic        rst_,
    input  logic        cmdValid,
    input  logic [5:0]  cmdIndex,
    input  logic [31:0] cmdArg,
    input  logic        cmdOk,
    output logic        cmdOut,
    output logic        cmdOe,
    output logic        readStart,
    output logic        readStop
);

    logic        accept;
    logic        respond;
    logic [5:0]  respIndex;
    logic [31:0] respArg;
    logic        respFixedCrc;
    logic        respRead;

    logic [15:0] rca;
    logic        appCmd;

    logic        pending;
    logic [3:0]  delayCount;
    logic        loadNow;
    logic [5:0]  pendIndex;
    logic [31:0] pendArg;
    logic        pendFixedCrc;
    logic        pendRead;

    logic [5:0]  bitCount;
    logic [47:0] shiftReg;
    logic [6:0]  crc;
    logic [6:0]  crcField;
    logic        crcPhase;

    // Busy from acceptance until the end bit has gone out
    assign accept   = cmdValid && cmdOk && !pending && !cmdOe;
    assign loadNow  = pending && (delayCount == 4'd0);
    assign readStop = accept && (cmdIndex == CMD_STOP);

    // ============================================================
    // Command decode
    // ============================================================
    always_comb begin
        respond      = 1'b0;
        respIndex    = cmdIndex;
        respArg      = '0;
        respFixedCrc = 1'b0;
        respRead     = 1'b0;
        case (cmdIndex)
            CMD_SEND_RCA: begin
                respond = 1'b1;
                respArg = {RCA_VALUE, R6_STATUS};
            end
            CMD_SELECT: begin
                respond = (cmdArg[31:16] == rca);
                respArg = R1_STATUS_SELECT;
            end
            CMD_SEND_IF_COND: begin
                respond = 1'b1;
                respArg = {20'h00000, cmdArg[11:0]};
            end
            CMD_STOP: begin
                respond = 1'b1;
                respArg = R1_STATUS_TRAN;
            end
            CMD_READ_MULTI: begin
                respond  = 1'b1;
                respArg  = R1_STATUS_TRAN;
                respRead = 1'b1;
            end
            CMD_APP: begin
                respond = 1'b1;
                respArg = R1_STATUS_APP;
            end
            ACMD_OP_COND: begin
                // Plain CMD41 is unknown to the card
                respond      = appCmd;
                respIndex    = R3_INDEX;
                respArg      = R3_OCR_READY;
                respFixedCrc = 1'b1;
            end
            default: begin
                respond = 1'b0;
            end
        endcase
    end

    // ============================================================
    // Card state, NCR delay and bit counter
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            rca        <= '0;
            appCmd     <= 1'b0;
            pending    <= 1'b0;
            delayCount <= '0;
            cmdOe      <= 1'b0;
            bitCount   <= '0;
        end else begin
            if (accept) begin
                appCmd <= (cmdIndex == CMD_APP);
                if (cmdIndex == CMD_GO_IDLE) begin
                    rca <= '0;
                end else if (cmdIndex == CMD_SEND_RCA) begin
                    rca <= RCA_VALUE;
                end
                if (respond) begin
                    pending    <= 1'b1;
                    delayCount <= 4'(NCR_CYCLES - 1);
                end
            end
            if (loadNow) begin
                pending  <= 1'b0;
                cmdOe    <= 1'b1;
                bitCount <= '0;
            end else if (pending) begin
                delayCount <= delayCount - 4'd1;
            end
            if (cmdOe) begin
                if (bitCount == 6'(CMD_FRAME_BITS - 1)) begin
                    cmdOe <= 1'b0;
                end else begin
                    bitCount <= bitCount + 6'd1;
                end
            end
        end
    end

    // Response payload, CRC slot left empty in the shift register
    always_ff @(posedge clk) begin
        if (accept) begin
            pendIndex    <= respIndex;
            pendArg      <= respArg;
            pendFixedCrc <= respFixedCrc;
            pendRead     <= respRead;
        end
        if (loadNow) begin
            shiftReg <= {2'b00, pendIndex, pendArg, 7'h00, 1'b1};
        end else if (cmdOe) begin
            shiftReg <= {shiftReg[46:0], 1'b1};
        end
    end

    sdCrc #(
        .WIDTH (CRC7_WIDTH),
        .POLY  (CRC7_POLY)
    ) i_crc7 (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (loadNow),
        .enable (cmdOe && (bitCount < 6'(CMD_FRAME_BITS - 8))),
        .din    (shiftReg[47]),
        .crc    (crc)
    );

    // Bits 40 to 46 come from the CRC instead of the shift register
    assign crcPhase = (bitCount >= 6'(CMD_FRAME_BITS - 8))
                   && (bitCount < 6'(CMD_FRAME_BITS - 1));
    assign crcField = pendFixedCrc ? R3_CRC : crc;

    assign cmdOut = !cmdOe ? 1'b1
                  : crcPhase ? crcField[3'(6'(CMD_FRAME_BITS - 2) - bitCount)]
                  : shiftReg[47];

    // Data starts right after the end bit of the CMD18 response
    assign readStart = cmdOe && pendRead && (bitCount == 6'(CMD_FRAME_BITS - 1));

endmodule

/* src/sdReadSender.sv */
`timescale 1ns/1ps

module sdReadSender
    import sdCardPkg::*;
(
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 readStart,
    input  logic                 readStop,
    output logic [DAT_LANES-1:0] datOut,
    output logic                 datOe
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_DATA,
        PH_CRC,
        PH_END,
        PH_GAP
    } phaseType;

    phaseType    phase;
    logic [9:0]  count;
    logic [7:0]  patternByte;
    logic [3:0]  dataNibble;
    logic [3:0]  crcSel;
    logic [15:0] laneCrc [DAT_LANES];
    logic        crcClear;
    logic        crcEnable;

    // ============================================================
    // Block sequencing
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            phase <= PH_IDLE;
            count <= '0;
        end else if (readStop) begin
            phase <= PH_IDLE;
        end else if (readStart) begin
            phase <= PH_START;
        end else begin
            case (phase)
                PH_START: begin
                    phase <= PH_DATA;
                    count <= '0;
                end
                PH_DATA: begin
                    if (count == 10'(BLOCK_NIBBLES - 1)) begin
                        phase <= PH_CRC;
                        count <= '0;
                    end else begin
                        count <= count + 10'd1;
                    end
                end
                PH_CRC: begin
                    if (count == 10'(CRC16_WIDTH - 1)) begin
                        phase <= PH_END;
                    end else begin
                        count <= count + 10'd1;
                    end
                end
                PH_END: begin
                    phase <= PH_GAP;
                    count <= '0;
                end
                PH_GAP: begin
                    if (count == 10'(BLOCK_GAP_CYCLES - 1)) begin
                        phase <= PH_START;
                    end else begin
                        count <= count + 10'd1;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // Byte k of the block is k mod 256, high nibble first
    assign patternByte = count[8:1];
    assign dataNibble  = count[0] ? patternByte[3:0] : patternByte[7:4];
    assign crcSel      = 4'(CRC16_WIDTH - 1) - count[3:0];

    // ============================================================
    // DAT lane CRC16, one per lane
    // ============================================================
    assign crcClear  = (phase == PH_START);
    assign crcEnable = (phase == PH_DATA);

    for (genvar lane = 0; lane < DAT_LANES; lane++) begin : genLaneCrc
        sdCrc #(
            .WIDTH (CRC16_WIDTH),
            .POLY  (CRC16_POLY)
        ) i_crc16 (
            .clk    (clk),
            .rst_   (rst_),
            .clear  (crcClear),
            .enable (crcEnable),
            .din    (datOut[lane]),
            .crc    (laneCrc[lane])
        );
    end

    always_comb begin
        datOe = (phase == PH_START) || (phase == PH_DATA)
             || (phase == PH_CRC) || (phase == PH_END);
        case (phase)
            PH_START: datOut = '0;
            PH_DATA:  datOut = dataNibble;
            PH_CRC: begin
                // Each lane sends its own CRC, MSB first
                for (int lane = 0; lane < DAT_LANES; lane++) begin
                    datOut[lane] = laneCrc[lane][crcSel];
                end
            end
            default:  datOut = '1;
        endcase
    end

endmodule

/* src/sdCardTop.sv */
`timescale 1ns/1ps

module sdCardTop
    import sdCardPkg::*;
(
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 cmdIn,
    output logic                 cmdOut,
    output logic                 cmdOe,
    output logic [DAT_LANES-1:0] datOut,
    output logic                 datOe
);

    logic        cmdValid;
    logic [5:0]  cmdIndex;
    logic [31:0] cmdArg;
    logic        cmdOk;
    logic        readStart;
    logic        readStop;

    sdCmdReceiver i_cmdReceiver (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdValid (cmdValid),
        .cmdIndex (cmdIndex),
        .cmdArg   (cmdArg),
        .cmdOk    (cmdOk)
    );

    sdCmdResponder i_cmdResponder (
        .clk       (clk),
        .rst_      (rst_),
        .cmdValid  (cmdValid),
        .cmdIndex  (cmdIndex),
        .cmdArg    (cmdArg),
        .cmdOk     (cmdOk),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe),
        .readStart (readStart),
        .readStop  (readStop)
    );

    sdReadSender i_readSender (
        .clk       (clk),
        .rst_      (rst_),
        .readStart (readStart),
        .readStop  (readStop),
        .datOut    (datOut),
        .datOe     (datOe)
    );

endmodule

/* verification/sdCard_assert.sv */
`timescale 1ns/1ps

module sdCard_assert
    import sdCardPkg::*;
(
    input logic clk,
    input logic rst_,
    input logic cmdOe,
    input logic datOe
);

    logic [6:0] oeRun;

    // Length of the current CMD drive burst
    always_ff @(posedge clk) begin
        if (!rst_ || !cmdOe) begin
            oeRun <= '0;
        end else begin
            oeRun <= oeRun + 7'd1;
        end
    end

    responseLength: assert property (@(posedge clk) disable iff (!rst_)
        $fell(cmdOe) |-> (oeRun == 7'(CMD_FRAME_BITS)))
        else $error("cmdOe burst did not last %0d cycles", CMD_FRAME_BITS);

    responseNotLong: assert property (@(posedge clk) disable iff (!rst_)
        cmdOe |-> (oeRun < 7'(CMD_FRAME_BITS)))
        else $error("cmdOe held past one response frame");

    // Both bus enables stay low in the first cycle out of reset
    resetQuiet: assert property (@(posedge clk)
        !rst_ |=> (!cmdOe && !datOe))
        else $error("bus driven in the cycle after reset");

endmodule

bind sdCardTop sdCard_assert i_assert (
    .clk   (clk),
    .rst_  (rst_),
    .cmdOe (cmdOe),
    .datOe (datOe)
);

/* verification/sdCardTb.sv */
`timescale 1ns/1ps

module sdCardTb
    import sdCardPkg::*;
();

    // Tests need about 4500 cycles in total
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int SILENCE_CYCLES = 60;

    logic        clk;
    logic        rst_;
    logic        cmdIn;
    logic        cmdOut;
    logic        cmdOe;
    logic [3:0]  datOut;
    logic        datOe;
    logic        cmdLine;
    logic [3:0]  datLine;

    int          checkCount;
    int          errorCount;
    int          testErrors;
    int          cycleCount;
    int          waited;
    logic [47:0] resp;

    // Pull-ups hold the bus lines high while the card is not driving
    assign cmdLine = cmdOe ? cmdOut : 1'b1;
    assign datLine = datOe ? datOut : 4'hF;

    sdCardTop i_dut (
        .clk    (clk),
        .rst_   (rst_),
        .cmdIn  (cmdIn),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe),
        .datOut (datOut),
        .datOe  (datOe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // ============================================================
    // Reference CRCs and frames
    // ============================================================
    // Long division of msg * x^7 by x^7 + x^3 + 1
    function automatic logic [6:0] crc7Of(input logic [39:0] msg);
        logic [46:0] rem;
        rem = {msg, 7'h00};
        for (int i = 0; i < 40; i++) begin
            if (rem[46]) begin
                rem[46:39] = rem[46:39] ^ {1'b1, CRC7_POLY};
            end
            rem = rem << 1;
        end
        return rem[46:40];
    endfunction

    function automatic logic [15:0] crc16Step(input logic [15:0] crc, input logic din);
        logic [15:0] shifted;
        shifted = {crc[14:0], 1'b0};
        if (din ^ crc[15]) begin
            shifted = shifted ^ CRC16_POLY;
        end
        return shifted;
    endfunction

    function automatic logic [47:0] respFrame(input logic [5:0] index, input logic [31:0] arg);
        logic [39:0] head;
        head = {2'b00, index, arg};
        return {head, crc7Of(head), 1'b1};
    endfunction

    // ============================================================
    // Host model and checks
    // ============================================================
    task automatic checkValue(input string name, input logic [47:0] got,
                              input logic [47:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic reportProblem(input string text);
        errorCount++;
        $display("Error: %s", text);
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testErrors) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // Returns in the cycle where the receiver flags the frame
    task automatic sendCommand(input logic [5:0] index, input logic [31:0] arg,
                               input logic badCrc);
        logic [39:0] head;
        logic [47:0] frame;
        head  = {2'b01, index, arg};
        frame = {head, crc7Of(head) ^ {6'd0, badCrc}, 1'b1};
        for (int i = 0; i < CMD_FRAME_BITS; i++) begin
            @(negedge clk);
            cmdIn = frame[47];
            frame = frame << 1;
        end
        @(negedge clk);
        cmdIn = 1'b1;
    endtask

    task automatic readResponse(output logic [47:0] frame, output int delay);
        frame = '1;
        delay = 0;
        @(negedge clk);
        while (!cmdOe && delay < NCR_CYCLES + 1) begin
            delay++;
            @(negedge clk);
        end
        if (!cmdOe) begin
            reportProblem("card did not drive CMD within the NCR window");
        end else begin
            frame = {frame[46:0], cmdLine};
            for (int i = 1; i < CMD_FRAME_BITS; i++) begin
                @(negedge clk);
                frame = {frame[46:0], cmdLine};
            end
        end
    endtask

    task automatic expectAnswer(input string name, input logic [47:0] expFrame);
        readResponse(resp, waited);
        checkValue(name, resp, expFrame);
    endtask

    task automatic expectSilence(input string what);
        int driven;
        driven = 0;
        repeat (SILENCE_CYCLES) begin
            @(negedge clk);
            if (cmdOe) begin
                driven++;
            end
        end
        if (driven != 0) begin
            reportProblem({what, " got a response although the card should ignore it"});
        end
    endtask

    // Checks one block; CRC and end nibble only when the whole block is read
    task automatic readBlock(input int dataCount, input int expGap);
        logic [3:0][15:0] laneCrc;
        logic [7:0]       byteVal;
        logic [3:0]       nib;
        int               gap;
        laneCrc = '0;
        gap     = 0;
        @(negedge clk);
        while (!datOe && gap < BLOCK_GAP_CYCLES + 1) begin
            gap++;
            @(negedge clk);
        end
        if (!datOe) begin
            reportProblem("no read block started on DAT");
            return;
        end
        checkValue("block gap", 48'(gap), 48'(expGap));
        checkValue("start nibble", 48'(datLine), 48'h0);
        for (int k = 0; k < dataCount; k++) begin
            @(negedge clk);
            byteVal = 8'(k / 2);
            nib     = k[0] ? byteVal[3:0] : byteVal[7:4];
            checkValue("data nibble", 48'(datLine), 48'(nib));
            laneCrc[0] = crc16Step(laneCrc[0], nib[0]);
            laneCrc[1] = crc16Step(laneCrc[1], nib[1]);
            laneCrc[2] = crc16Step(laneCrc[2], nib[2]);
            laneCrc[3] = crc16Step(laneCrc[3], nib[3]);
        end
        if (dataCount == BLOCK_NIBBLES) begin
            for (int i = 0; i < CRC16_WIDTH; i++) begin
                @(negedge clk);
                nib = {laneCrc[3][15], laneCrc[2][15], laneCrc[1][15], laneCrc[0][15]};
                checkValue("CRC16 nibble", 48'(datLine), 48'(nib));
                laneCrc[0] <<= 1;
                laneCrc[1] <<= 1;
                laneCrc[2] <<= 1;
                laneCrc[3] <<= 1;
            end
            @(negedge clk);
            checkValue("end nibble", 48'(datLine), 48'hF);
            checkValue("datOe at end nibble", 48'(datOe), 48'h1);
        end
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic ifCondResponse();
        sendCommand(CMD_SEND_IF_COND, 32'h000001AA, 1'b0);
        readResponse(resp, waited);
        checkValue("CMD8 response", resp, respFrame(CMD_SEND_IF_COND, 32'h000001AA));
        checkValue("CMD8 NCR delay", 48'(waited), 48'(NCR_CYCLES));
        finishTest("CMD8 interface condition");
    endtask

    task automatic initSequence();
        sendCommand(CMD_GO_IDLE, 32'h0, 1'b0);
        expectSilence("CMD0");
        sendCommand(CMD_APP, 32'h0, 1'b0);
        expectAnswer("CMD55 response", respFrame(CMD_APP, R1_STATUS_APP));
        sendCommand(ACMD_OP_COND, 32'h40FF8000, 1'b0);
        // R3 has a fixed index and CRC field
        expectAnswer("ACMD41 response", {2'b00, R3_INDEX, R3_OCR_READY, R3_CRC, 1'b1});
        sendCommand(CMD_SEND_RCA, 32'h0, 1'b0);
        expectAnswer("CMD3 response", respFrame(CMD_SEND_RCA, 32'hAAAA0520));
        sendCommand(CMD_SELECT, 32'hAAAA0000, 1'b0);
        expectAnswer("CMD7 response", respFrame(CMD_SELECT, R1_STATUS_SELECT));
        finishTest("init sequence");
    endtask

    task automatic rejectedCommands();
        sendCommand(CMD_SEND_IF_COND, 32'h000001AA, 1'b1);
        expectSilence("CMD8 with a corrupted CRC");
        sendCommand(6'd9, 32'h0, 1'b0);
        expectSilence("CMD9");
        sendCommand(CMD_SELECT, 32'h12340000, 1'b0);
        expectSilence("CMD7 with RCA 1234");
        sendCommand(ACMD_OP_COND, 32'h40FF8000, 1'b0);
        expectSilence("CMD41 without CMD55");
        finishTest("rejected commands");
    endtask

    task automatic firstReadBlock();
        sendCommand(CMD_READ_MULTI, 32'h0, 1'b0);
        expectAnswer("CMD18 response", respFrame(CMD_READ_MULTI, R1_STATUS_TRAN));
        readBlock(BLOCK_NIBBLES, 0);
        finishTest("CMD18 first block");
    endtask

    task automatic stopDuringBlock();
        int dataSeen;
        dataSeen = 0;
        readBlock(64, BLOCK_GAP_CYCLES);
        sendCommand(CMD_STOP, 32'h0, 1'b0);
        checkValue("datOe before stop", 48'(datOe), 48'h1);
        fork
            expectAnswer("CMD12 response", respFrame(CMD_STOP, R1_STATUS_TRAN));
            begin
                @(negedge clk);
                checkValue("datOe after stop", 48'(datOe), 48'h0);
            end
        join
        repeat (BLOCK_NIBBLES + 64) begin
            @(negedge clk);
            if (datOe) begin
                dataSeen++;
            end
        end
        checkValue("datOe cycles after stop", 48'(dataSeen), 48'h0);
        finishTest("second block and CMD12");
    endtask

    task automatic resetClearsRca();
        sendCommand(CMD_READ_MULTI, 32'h0, 1'b0);
        expectAnswer("CMD18 response", respFrame(CMD_READ_MULTI, R1_STATUS_TRAN));
        repeat (100) @(negedge clk);
        // Reset lands in the middle of a CMD8 response and a data block
        sendCommand(CMD_SEND_IF_COND, 32'h000001AA, 1'b0);
        repeat (10) @(negedge clk);
        checkValue("cmdOe before reset", 48'(cmdOe), 48'h1);
        checkValue("datOe before reset", 48'(datOe), 48'h1);
        rst_ = 1'b0;
        repeat (10) @(negedge clk);
        rst_ = 1'b1;
        checkValue("datOe after reset", 48'(datOe), 48'h0);
        checkValue("cmdOe after reset", 48'(cmdOe), 48'h0);
        sendCommand(CMD_SELECT, 32'hAAAA0000, 1'b0);
        expectSilence("CMD7 with RCA AAAA after reset");
        finishTest("mid-run reset");
    endtask

    initial begin
        rst_       = 1'b0;
        cmdIn      = 1'b1;
        checkCount = 0;
        errorCount = 0;
        testErrors = 0;
        repeat (10) @(negedge clk);
        rst_ = 1'b1;

        ifCondResponse();
        initSequence();
        rejectedCommands();
        firstReadBlock();
        stopDuringBlock();
        resetClearsRca();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/sdCardPkg.sv
src/sdCrc.sv
src/sdCmdReceiver.sv
src/sdCmdResponder.sv
src/sdReadSender.sv
src/sdCardTop.sv
verification/sdCard_assert.sv
verification/sdCardTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sdCardTb -f vlog.f -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
